// ==== tb.f ====
source/fetch_pkg.sv
source/fetch_pc_gen.sv
source/fetch_icache.sv
source/mem_read_port.sv
source/fetch_instr_buffer.sv
source/fetch_top.sv
test/fetch_properties.sv
test/tb_fetch_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

LOG=sim.log

verilator --binary --assert --top-module tb_fetch_top -f tb.f -o tb_fetch_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch_top +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== test/tb_fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam addr_t       BOOT_PC      = 32'h0000_2000;
    localparam data_t       DATA_MASK    = 32'hA5A5_5A5A;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_PAIRS    = 40;
    localparam int          WAIT_LIMIT   = 100;
    localparam logic [31:0] LCG_SEED     = 32'h2279ab4f;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  mem_req_o;
    addr_t mem_addr_o;
    data_t mem_rdata_i;
    logic  mem_rvalid_i;
    logic  issue_valid_o;
    addr_t issue_pc_0_o;
    data_t issue_instr_0_o;
    addr_t issue_pc_1_o;
    data_t issue_instr_1_o;

    // Memory model bookkeeping
    bit outstanding = 1'b0;
    int req_count = 0;

    int check_errors = 0;
    int mem_errors = 0;
    int reset_errors = 0;
    int overlap_errors = 0;
    int prop_errors;

    assign prop_errors = i_dut.i_icache.i_props.fail_count;

    fetch_top #(
        .RESET_PC (BOOT_PC)
    ) i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_rdata_i     (mem_rdata_i),
        .mem_rvalid_i    (mem_rvalid_i),
        .issue_valid_o   (issue_valid_o),
        .issue_pc_0_o    (issue_pc_0_o),
        .issue_instr_0_o (issue_instr_0_o),
        .issue_pc_1_o    (issue_pc_1_o),
        .issue_instr_1_o (issue_instr_1_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Outputs stay zero until the first memory request
    task automatic wait_for_first_request(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (mem_req_o) begin
                seen = 1'b1;
            end else begin
                assert (!issue_valid_o && mem_addr_o == '0 && issue_pc_0_o == '0 &&
                        issue_instr_0_o == '0 && issue_pc_1_o == '0 &&
                        issue_instr_1_o == '0)
                else begin
                    check_errors++;
                    $display("Outputs not zero between reset and the first request");
                end
            end
        end
    endtask

    task automatic wait_for_issue(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            seen = issue_valid_o;
        end
    endtask

    task automatic finish_run();
        int total;
        total = check_errors + mem_errors + reset_errors + overlap_errors + prop_errors;
        $display("Errors: checks=%0d memory=%0d reset=%0d overlap=%0d properties=%0d",
                 check_errors, mem_errors, reset_errors, overlap_errors, prop_errors);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    reset_idle_a: assert property (
        @(negedge clk) !rst_n |-> (!issue_valid_o && !mem_req_o && mem_addr_o == '0 &&
            issue_pc_0_o == '0 && issue_instr_0_o == '0 && issue_pc_1_o == '0 &&
            issue_instr_1_o == '0)
    ) else begin
        reset_errors++;
        $display("Outputs not idle while reset is asserted");
    end

    // Memory model with random latency of 1 to 6 cycles
    initial begin : memory_model
        logic [31:0] lcg_state;
        int          countdown;
        addr_t       resp_addr;
        addr_t       expected_addr;
        lcg_state = LCG_SEED;
        countdown = 0;
        resp_addr = '0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (mem_req_o) begin
                // A new request finds no earlier read still in flight
                assert (!outstanding)
                else begin
                    overlap_errors++;
                    $display("Memory request issued while an earlier read was unanswered");
                end
                expected_addr = BOOT_PC + INSTR_BYTES * addr_t'(req_count);
                assert (mem_addr_o == expected_addr)
                else begin
                    mem_errors++;
                    $display("[FAIL] mem_addr_o = %h, expected %h", mem_addr_o, expected_addr);
                end
                req_count++;
                lcg_state = lcg_next(lcg_state);
                countdown = 1 + int'(lcg_state[23:16] % 8'd6);
                resp_addr = mem_addr_o;
            end
            if (mem_rvalid_i) begin
                outstanding = 1'b0;
            end
            if (mem_req_o) begin
                outstanding = 1'b1;
            end
            @(posedge clk);
            #1;
            mem_rvalid_i = 1'b0;
            mem_rdata_i = '0;
            if (countdown > 0) begin
                countdown--;
                if (countdown == 0) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i = resp_addr ^ DATA_MASK;
                end
            end
        end
    end

    initial begin : main_sequence
        bit    seen;
        bit    timed_out;
        int    pair_idx;
        addr_t expected_pc;
        timed_out = 1'b0;
        pair_idx = 0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_for_first_request(seen);
        if (!seen) begin
            check_errors++;
            timed_out = 1'b1;
            $display("No memory request within %0d cycles after reset", WAIT_LIMIT);
        end
        while (!timed_out && pair_idx < NUM_PAIRS) begin
            wait_for_issue(seen);
            if (!seen) begin
                check_errors++;
                timed_out = 1'b1;
                $display("Timed out waiting for issued pair %0d", pair_idx);
            end else begin
                expected_pc = BOOT_PC + addr_t'(8 * pair_idx);
                assert (issue_pc_0_o == expected_pc)
                else begin
                    check_errors++;
                    $display("[FAIL] issue_pc_0_o = %h, expected %h", issue_pc_0_o, expected_pc);
                end
                assert (issue_pc_1_o == expected_pc + INSTR_BYTES)
                else begin
                    check_errors++;
                    $display("[FAIL] issue_pc_1_o = %h, expected %h", issue_pc_1_o,
                             expected_pc + INSTR_BYTES);
                end
                assert (issue_instr_0_o == (expected_pc ^ DATA_MASK))
                else begin
                    check_errors++;
                    $display("[FAIL] issue_instr_0_o = %h, expected %h", issue_instr_0_o,
                             expected_pc ^ DATA_MASK);
                end
                assert (issue_instr_1_o == ((expected_pc + INSTR_BYTES) ^ DATA_MASK))
                else begin
                    check_errors++;
                    $display("[FAIL] issue_instr_1_o = %h, expected %h", issue_instr_1_o,
                             (expected_pc + INSTR_BYTES) ^ DATA_MASK);
                end
                // Two reads per pair, the next pair has not reached memory yet
                assert (req_count == 2 * (pair_idx + 1))
                else begin
                    check_errors++;
                    $display("[FAIL] req_count = %h, expected %h", req_count,
                             2 * (pair_idx + 1));
                end
                pair_idx++;
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== test/fetch_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_properties
    import fetch_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input addr_t raddr_1_i,
    input addr_t raddr_2_i,
    input logic  stallreq_i,
    input logic  rvalid_1_i,
    input logic  rvalid_2_i,
    input addr_t axi_addr_i,
    input logic  axi_busy_i
);

    int pair_fails = 0;
    int strobe_fails = 0;
    int stall_fails = 0;
    int fail_count;

    assign fail_count = pair_fails + strobe_fails + stall_fails;

    // Return pulses never share a cycle
    valid_exclusive_a: assert property (
        @(posedge clk) disable iff (!rst_n) !(rvalid_1_i && rvalid_2_i)
    ) else begin
        pair_fails++;
        $error("rvalid_1 and rvalid_2 high in the same cycle");
    end

    // Strobe only launched once the port was free
    strobe_when_free_a: assert property (
        @(posedge clk) disable iff (!rst_n) (axi_addr_i != '0) |-> !$past(axi_busy_i)
    ) else begin
        strobe_fails++;
        $error("Read strobe launched while the memory port was busy");
    end

    // Accepted pair holds the fetch stage from the next cycle on
    stall_after_accept_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((raddr_1_i != '0 || raddr_2_i != '0) && !stallreq_i) |=> stallreq_i
    ) else begin
        stall_fails++;
        $error("Stall request missing in the cycle after a pair was accepted");
    end

endmodule

bind fetch_icache fetch_properties i_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .raddr_1_i  (raddr_1_i),
    .raddr_2_i  (raddr_2_i),
    .stallreq_i (stallreq_o),
    .rvalid_1_i (rvalid_1_o),
    .rvalid_2_i (rvalid_2_o),
    .axi_addr_i (axi_addr_o),
    .axi_busy_i (axi_busy_i)
);

`default_nettype wire

// ==== source/fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h0000_0100
) (
    input  logic  clk,
    input  logic  rst_n,

    // External memory
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    input  data_t mem_rdata_i,
    input  logic  mem_rvalid_i,

    // Issue stage
    output logic  issue_valid_o,
    output addr_t issue_pc_0_o,
    output data_t issue_instr_0_o,
    output addr_t issue_pc_1_o,
    output data_t issue_instr_1_o
);

    // Fetch address pair and the stall back
    addr_t raddr_1;
    addr_t raddr_2;
    logic  stallreq;

    // Returned words
    logic  rvalid_1;
    logic  rvalid_2;
    addr_t ret_addr_1;
    addr_t ret_addr_2;
    data_t ret_data_1;
    data_t ret_data_2;

    // Cache to memory port
    addr_t axi_addr;
    data_t axi_data;
    logic  axi_busy;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) i_pc_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall_i   (stallreq),
        .raddr_1_o (raddr_1),
        .raddr_2_o (raddr_2)
    );

    fetch_icache i_icache (
        .clk        (clk),
        .rst_n      (rst_n),
        .raddr_1_i  (raddr_1),
        .raddr_2_i  (raddr_2),
        .stallreq_o (stallreq),
        .rvalid_1_o (rvalid_1),
        .rvalid_2_o (rvalid_2),
        .raddr_1_o  (ret_addr_1),
        .raddr_2_o  (ret_addr_2),
        .rdata_1_o  (ret_data_1),
        .rdata_2_o  (ret_data_2),
        .axi_addr_o (axi_addr),
        .axi_data_i (axi_data),
        .axi_busy_i (axi_busy)
    );

    mem_read_port i_mem_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr_i       (axi_addr),
        .data_o       (axi_data),
        .busy_o       (axi_busy),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i)
    );

    fetch_instr_buffer i_instr_buf (
        .clk             (clk),
        .rst_n           (rst_n),
        .rvalid_1_i      (rvalid_1),
        .rvalid_2_i      (rvalid_2),
        .raddr_1_i       (ret_addr_1),
        .raddr_2_i       (ret_addr_2),
        .rdata_1_i       (ret_data_1),
        .rdata_2_i       (ret_data_2),
        .issue_valid_o   (issue_valid_o),
        .issue_pc_0_o    (issue_pc_0_o),
        .issue_instr_0_o (issue_instr_0_o),
        .issue_pc_1_o    (issue_pc_1_o),
        .issue_instr_1_o (issue_instr_1_o)
    );

endmodule

`default_nettype wire

// ==== source/fetch_instr_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_instr_buffer
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // Words from the cache, first word always comes first
    input  logic  rvalid_1_i,
    input  logic  rvalid_2_i,
    input  addr_t raddr_1_i,
    input  addr_t raddr_2_i,
    input  data_t rdata_1_i,
    input  data_t rdata_2_i,

    // Issued pair, one-cycle pulse
    output logic  issue_valid_o,
    output addr_t issue_pc_0_o,
    output data_t issue_instr_0_o,
    output addr_t issue_pc_1_o,
    output data_t issue_instr_1_o
);

    logic  half_full_q;
    addr_t hold_addr_q;
    data_t hold_data_q;
    logic  pair_done;

    // Second word without a held first word is dropped
    assign pair_done = rvalid_2_i && half_full_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_full_q <= 1'b0;
        end else if (rvalid_1_i) begin
            half_full_q <= 1'b1;
        end else if (pair_done) begin
            half_full_q <= 1'b0;
        end
    end

    // Slot 0 waiting for its partner
    always_ff @(posedge clk) begin
        if (rvalid_1_i) begin
            hold_addr_q <= raddr_1_i;
            hold_data_q <= rdata_1_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid_o   <= 1'b0;
            issue_pc_0_o    <= '0;
            issue_instr_0_o <= '0;
            issue_pc_1_o    <= '0;
            issue_instr_1_o <= '0;
        end else begin
            issue_valid_o <= pair_done;
            if (pair_done) begin
                issue_pc_0_o    <= hold_addr_q;
                issue_instr_0_o <= hold_data_q;
                issue_pc_1_o    <= raddr_2_i;
                issue_instr_1_o <= rdata_2_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_read_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_read_port
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // Cache side
    input  addr_t addr_i,
    output data_t data_o,
    output logic  busy_o,

    // External memory
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    input  data_t mem_rdata_i,
    input  logic  mem_rvalid_i
);

    logic strobe;
    logic pending_q;
    logic resp_hit;

    assign strobe = (addr_i != '0);

    // Only one read in flight, later strobes are not forwarded
    assign mem_req_o  = strobe && !pending_q;
    assign mem_addr_o = mem_req_o ? addr_i : '0;

    // A response with nothing outstanding is ignored
    assign resp_hit = pending_q && mem_rvalid_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (mem_req_o) begin
            pending_q <= 1'b1;
        end else if (resp_hit) begin
            pending_q <= 1'b0;
        end
    end

    // High from the strobe on, low again in the data cycle
    assign busy_o = pending_q ? !mem_rvalid_i : strobe;
    assign data_o = resp_hit ? mem_rdata_i : '0;

endmodule

`default_nettype wire

// ==== source/fetch_icache.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_icache
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // Fetch stage side, zero address means no request
    input  addr_t raddr_1_i,
    input  addr_t raddr_2_i,
    output logic  stallreq_o,
    output logic  rvalid_1_o,
    output logic  rvalid_2_o,
    output addr_t raddr_1_o,
    output addr_t raddr_2_o,
    output data_t rdata_1_o,
    output data_t rdata_2_o,

    // Memory port side, busy drops in the cycle data is ready
    output addr_t axi_addr_o,
    input  data_t axi_data_i,
    input  logic  axi_busy_i
);

    icache_state_e state_q;
    icache_state_e state_d;

    // Address pair kept for the whole transaction
    addr_t pair_addr_1_q;
    addr_t pair_addr_2_q;

    logic pair_valid;
    logic port_free;

    assign pair_valid = (raddr_1_i != '0) || (raddr_2_i != '0);
    assign port_free  = !axi_busy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ACCEPT_ADDR;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ACCEPT_ADDR: begin
                if (pair_valid) begin
                    state_d = IN_TRANSACTION_1;
                end
            end
            IN_TRANSACTION_1: begin
                if (port_free) begin
                    state_d = IN_TRANSACTION_2;
                end
            end
            IN_TRANSACTION_2: begin
                if (port_free) begin
                    state_d = ACCEPT_ADDR;
                end
            end
            default: begin
                state_d = ACCEPT_ADDR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state_q == ACCEPT_ADDR && pair_valid) begin
            pair_addr_1_q <= raddr_1_i;
            pair_addr_2_q <= raddr_2_i;
        end
    end

    // Fetch stage is held for the whole transaction
    assign stallreq_o = (state_q != ACCEPT_ADDR);

    // Read strobes, one cycle each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            axi_addr_o <= '0;
        end else begin
            axi_addr_o <= '0;
            case (state_q)
                ACCEPT_ADDR: begin
                    if (raddr_1_i != '0 && port_free) begin
                        axi_addr_o <= raddr_1_i;
                    end
                end
                IN_TRANSACTION_1: begin
                    // Second read goes out as the first word comes back
                    if (pair_addr_2_q != '0 && port_free) begin
                        axi_addr_o <= pair_addr_2_q;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Returned words paired with their own address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_1_o <= 1'b0;
            rvalid_2_o <= 1'b0;
            raddr_1_o  <= '0;
            raddr_2_o  <= '0;
            rdata_1_o  <= '0;
            rdata_2_o  <= '0;
        end else begin
            rvalid_1_o <= 1'b0;
            rvalid_2_o <= 1'b0;
            raddr_1_o  <= '0;
            raddr_2_o  <= '0;
            rdata_1_o  <= '0;
            rdata_2_o  <= '0;
            if (state_q == IN_TRANSACTION_1 && port_free) begin
                rvalid_1_o <= 1'b1;
                raddr_1_o  <= pair_addr_1_q;
                rdata_1_o  <= axi_data_i;
            end
            if (state_q == IN_TRANSACTION_2 && port_free) begin
                rvalid_2_o <= 1'b1;
                raddr_2_o  <= pair_addr_2_q;
                rdata_2_o  <= axi_data_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_pc_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_gen
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h0000_0100
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall_i,
    output addr_t raddr_1_o,
    output addr_t raddr_2_o
);

    pc_gen_state_e state_q;
    addr_t         pc_q;

    // A pair is on the outputs for one cycle only, zero otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= PC_ISSUE;
            pc_q      <= RESET_PC;
            raddr_1_o <= '0;
            raddr_2_o <= '0;
        end else begin
            raddr_1_o <= '0;
            raddr_2_o <= '0;
            case (state_q)
                PC_ISSUE: begin
                    raddr_1_o <= pc_q;
                    raddr_2_o <= pc_q + INSTR_BYTES;
                    // Two instructions per pair
                    pc_q      <= pc_q + (INSTR_BYTES << 1);
                    state_q   <= PC_WAIT_STALL;
                end
                PC_WAIT_STALL: begin
                    // Stall shows up one cycle after the cache takes the pair
                    if (stall_i) begin
                        state_q <= PC_WAIT_FREE;
                    end
                end
                PC_WAIT_FREE: begin
                    if (!stall_i) begin
                        state_q <= PC_ISSUE;
                    end
                end
                default: begin
                    state_q <= PC_ISSUE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Widths are fixed because a zero address doubles as "no request"
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Byte step between two sequential instructions
    localparam addr_t INSTR_BYTES = 32'd4;

    typedef enum logic [1:0] {
        ACCEPT_ADDR      = 2'd0,
        IN_TRANSACTION_1 = 2'd1,
        IN_TRANSACTION_2 = 2'd2
    } icache_state_e;

    typedef enum logic [1:0] {
        PC_ISSUE      = 2'd0,
        PC_WAIT_STALL = 2'd1,
        PC_WAIT_FREE  = 2'd2
    } pc_gen_state_e;

endpackage

`default_nettype wire
